// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN         32
`define ILEN         32
`define NREGS        32
`define REG_AW       5
// first fetch address
`define RESET_VECTOR 32'h0000_0000

`endif

// ==== rtl/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE
    } cmp_e;

    typedef struct packed {
        logic use_pc;   // source 1 is the pc
        logic use_imm;  // source 2 is the immediate
    } src_ctrl_s;

    typedef struct packed {
        logic    en;
        alu_op_e op;
    } alu_ctrl_s;

    typedef struct packed {
        logic en;
        logic jump;  // unconditional, links pc+4
        cmp_e cmp;
    } bru_ctrl_s;

    typedef struct packed {
        logic               rf_we;
        logic [`REG_AW-1:0] rd;
    } wb_ctrl_s;

    // one record per committed instruction
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } retire_s;

endpackage

// ==== rtl/core_top.sv ====
`include "core_config.svh"
`default_nettype none

module core_top (
    input  var logic              clk_i,
    input  var logic              rst_i,
    output var logic [`XLEN-1:0]  imem_addr_o,
    input  var logic [`ILEN-1:0]  imem_rdata_i,
    output var core_pkg::retire_s retire_o
);

    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        core_pkg::alu_ctrl_s alu_ctrl;
        core_pkg::bru_ctrl_s bru_ctrl;
        core_pkg::wb_ctrl_s  wb_ctrl;
        logic                fwd1; // take commit result in execute
        logic                fwd2;
        logic [`XLEN-1:0]    src1;
        logic [`XLEN-1:0]    src2;
        logic [`XLEN-1:0]    imm;
    } idex_s;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic               tkn;
        logic [`XLEN-1:0]   tkn_pc;
        core_pkg::wb_ctrl_s wb_ctrl;
        logic [`XLEN-1:0]   rslt;
    } excm_s;

    logic [`XLEN-1:0] pc;         // pc of the word now in decode
    logic             idex_valid;
    idex_s            idex;
    logic             excm_valid;
    excm_s            excm;

    logic cm_flush;
    logic cm_we;
    assign cm_flush = excm_valid && excm.tkn; // taken branch or jal at commit
    assign cm_we    = excm_valid && excm.wb_ctrl.rf_we;

    // fetch
    logic [`XLEN-1:0] npc;
    assign npc = rst_i    ? `RESET_VECTOR :
                 cm_flush ? excm.tkn_pc   :
                            pc + 'd4;
    assign imem_addr_o = npc; // word comes back next cycle

    always_ff @(posedge clk_i) begin
        pc <= npc;
    end

    // decode
    isa_pkg::insn_u      id_insn;
    core_pkg::src_ctrl_s id_src_ctrl;
    core_pkg::alu_ctrl_s id_alu_ctrl;
    core_pkg::bru_ctrl_s id_bru_ctrl;
    core_pkg::wb_ctrl_s  id_wb_ctrl;
    logic [`REG_AW-1:0]  id_rs1;
    logic [`REG_AW-1:0]  id_rs2;
    logic [`XLEN-1:0]    id_imm;
    logic [`XLEN-1:0]    id_rdata1;
    logic [`XLEN-1:0]    id_rdata2;

    assign id_insn = imem_rdata_i;

    decoder u_decoder (
        .insn_i     (id_insn    ),
        .src_ctrl_o (id_src_ctrl),
        .alu_ctrl_o (id_alu_ctrl),
        .bru_ctrl_o (id_bru_ctrl),
        .wb_ctrl_o  (id_wb_ctrl ),
        .rs1_o      (id_rs1     ),
        .rs2_o      (id_rs2     ),
        .imm_o      (id_imm     )
    );

    regfile u_regfile (
        .clk_i    (clk_i          ),
        .rs1_i    (id_rs1         ),
        .rs2_i    (id_rs2         ),
        .rdata1_o (id_rdata1      ),
        .rdata2_o (id_rdata2      ),
        .we_i     (cm_we          ),
        .rd_i     (excm.wb_ctrl.rd),
        .wdata_i  (excm.rslt      )
    );

    // forwarding, commit into decode now or into execute next cycle
    logic id_fwd1_cm;
    logic id_fwd2_cm;
    logic id_fwd1_ex;
    logic id_fwd2_ex;
    assign id_fwd1_cm = cm_we && (excm.wb_ctrl.rd == id_rs1);
    assign id_fwd2_cm = cm_we && (excm.wb_ctrl.rd == id_rs2);
    assign id_fwd1_ex = idex_valid && idex.wb_ctrl.rf_we && (idex.wb_ctrl.rd == id_rs1) &&
                        !id_src_ctrl.use_pc;
    assign id_fwd2_ex = idex_valid && idex.wb_ctrl.rf_we && (idex.wb_ctrl.rd == id_rs2) &&
                        !id_src_ctrl.use_imm;

    logic [`XLEN-1:0] id_src1;
    logic [`XLEN-1:0] id_src2;
    assign id_src1 = id_src_ctrl.use_pc  ? pc        :
                     id_fwd1_cm          ? excm.rslt :
                                           id_rdata1;
    assign id_src2 = id_src_ctrl.use_imm ? id_imm    :
                     id_fwd2_cm          ? excm.rslt :
                                           id_rdata2;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            idex_valid <= 1'b0;
        end else begin
            idex_valid <= !cm_flush; // decode holds a word every cycle
        end
        idex.pc       <= pc;
        idex.alu_ctrl <= id_alu_ctrl;
        idex.bru_ctrl <= id_bru_ctrl;
        idex.wb_ctrl  <= id_wb_ctrl;
        idex.fwd1     <= id_fwd1_ex;
        idex.fwd2     <= id_fwd2_ex;
        idex.src1     <= id_src1;
        idex.src2     <= id_src2;
        idex.imm      <= id_imm;
    end

    // execute
    logic [`XLEN-1:0] ex_src1;
    logic [`XLEN-1:0] ex_src2;
    logic [`XLEN-1:0] ex_rslt;
    logic             ex_tkn;
    logic [`XLEN-1:0] ex_tkn_pc;
    assign ex_src1 = idex.fwd1 ? excm.rslt : idex.src1;
    assign ex_src2 = idex.fwd2 ? excm.rslt : idex.src2;

    exec_unit u_exec_unit (
        .alu_ctrl_i (idex.alu_ctrl),
        .bru_ctrl_i (idex.bru_ctrl),
        .src1_i     (ex_src1      ),
        .src2_i     (ex_src2      ),
        .pc_i       (idex.pc      ),
        .imm_i      (idex.imm     ),
        .rslt_o     (ex_rslt      ),
        .tkn_o      (ex_tkn       ),
        .tkn_pc_o   (ex_tkn_pc    )
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            excm_valid <= 1'b0;
        end else begin
            excm_valid <= idex_valid && !cm_flush;
        end
        excm.pc      <= idex.pc;
        excm.tkn     <= ex_tkn;
        excm.tkn_pc  <= ex_tkn_pc;
        excm.wb_ctrl <= idex.wb_ctrl;
        excm.rslt    <= ex_rslt;
    end

    // commit
    assign retire_o = '{
        valid: excm_valid,
        pc:    excm.pc,
        we:    cm_we,
        rd:    excm.wb_ctrl.rd,
        data:  excm.rslt
    };

    a_reset_clears: assert property (@(posedge clk_i) rst_i |=> !idex_valid && !excm_valid)
        else $error("stage valid set in cycle after reset");
    a_addr_aligned: assert property (@(posedge clk_i) imem_addr_o[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
`include "core_config.svh"
`default_nettype none

module decoder (
    input  var isa_pkg::insn_u      insn_i,
    output var core_pkg::src_ctrl_s src_ctrl_o,
    output var core_pkg::alu_ctrl_s alu_ctrl_o,
    output var core_pkg::bru_ctrl_s bru_ctrl_o,
    output var core_pkg::wb_ctrl_s  wb_ctrl_o,
    output var logic [`REG_AW-1:0]  rs1_o,
    output var logic [`REG_AW-1:0]  rs2_o,
    output var logic [`XLEN-1:0]    imm_o
);

    logic              legal;
    logic              is_alu;
    logic              is_bru;
    logic              jump;
    logic              writes;
    logic              use_pc;
    logic              use_imm;
    core_pkg::alu_op_e alu_op;
    core_pkg::cmp_e    cmp;

    always_comb begin
        legal   = 1'b0;
        is_alu  = 1'b0;
        is_bru  = 1'b0;
        jump    = 1'b0;
        writes  = 1'b0;
        use_pc  = 1'b0;
        use_imm = 1'b0;
        alu_op  = core_pkg::ALU_ADD;
        cmp     = core_pkg::CMP_EQ;
        imm_o   = '0;
        case (insn_i.r.opcode)
            isa_pkg::OP: begin
                legal  = 1'b1;
                is_alu = 1'b1;
                writes = 1'b1;
                case ({insn_i.r.funct7, insn_i.r.funct3})
                    {isa_pkg::F7_BASE, isa_pkg::F3_ADD}:  alu_op = core_pkg::ALU_ADD;
                    {isa_pkg::F7_ALT,  isa_pkg::F3_ADD}:  alu_op = core_pkg::ALU_SUB;
                    {isa_pkg::F7_BASE, isa_pkg::F3_SLL}:  alu_op = core_pkg::ALU_SLL;
                    {isa_pkg::F7_BASE, isa_pkg::F3_SLT}:  alu_op = core_pkg::ALU_SLT;
                    {isa_pkg::F7_BASE, isa_pkg::F3_SLTU}: alu_op = core_pkg::ALU_SLTU;
                    {isa_pkg::F7_BASE, isa_pkg::F3_XOR}:  alu_op = core_pkg::ALU_XOR;
                    {isa_pkg::F7_BASE, isa_pkg::F3_SR}:   alu_op = core_pkg::ALU_SRL;
                    {isa_pkg::F7_ALT,  isa_pkg::F3_SR}:   alu_op = core_pkg::ALU_SRA;
                    {isa_pkg::F7_BASE, isa_pkg::F3_OR}:   alu_op = core_pkg::ALU_OR;
                    {isa_pkg::F7_BASE, isa_pkg::F3_AND}:  alu_op = core_pkg::ALU_AND;
                    default:                              legal  = 1'b0;
                endcase
            end
            isa_pkg::OP_IMM: begin
                legal   = 1'b1;
                is_alu  = 1'b1;
                writes  = 1'b1;
                use_imm = 1'b1;
                imm_o   = {{(`XLEN-12){insn_i.i.imm[11]}}, insn_i.i.imm};
                case (insn_i.i.funct3)
                    isa_pkg::F3_ADD:  alu_op = core_pkg::ALU_ADD;
                    isa_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
                    isa_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
                    isa_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
                    isa_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
                    isa_pkg::F3_AND:  alu_op = core_pkg::ALU_AND;
                    isa_pkg::F3_SLL: begin
                        alu_op = core_pkg::ALU_SLL;
                        legal  = (insn_i.r.funct7 == isa_pkg::F7_BASE);
                    end
                    default: begin // shift right, funct7 sits in the upper immediate
                        alu_op = (insn_i.r.funct7 == isa_pkg::F7_ALT) ? core_pkg::ALU_SRA
                                                                      : core_pkg::ALU_SRL;
                        legal  = (insn_i.r.funct7 == isa_pkg::F7_BASE) ||
                                 (insn_i.r.funct7 == isa_pkg::F7_ALT);
                    end
                endcase
            end
            isa_pkg::LUI: begin
                legal   = 1'b1;
                is_alu  = 1'b1;
                writes  = 1'b1;
                use_imm = 1'b1;
                alu_op  = core_pkg::ALU_PASSB;
                imm_o   = {insn_i.u.imm31_12, 12'b0};
            end
            isa_pkg::BRANCH: begin
                legal  = 1'b1;
                is_bru = 1'b1;
                imm_o  = {{(`XLEN-12){insn_i.b.imm12}}, insn_i.b.imm11,
                          insn_i.b.imm10_5, insn_i.b.imm4_1, 1'b0};
                case (insn_i.b.funct3)
                    isa_pkg::F3_BEQ: cmp   = core_pkg::CMP_EQ;
                    isa_pkg::F3_BNE: cmp   = core_pkg::CMP_NE;
                    isa_pkg::F3_BLT: cmp   = core_pkg::CMP_LT;
                    isa_pkg::F3_BGE: cmp   = core_pkg::CMP_GE;
                    default:         legal = 1'b0;
                endcase
            end
            isa_pkg::JAL: begin
                legal   = 1'b1;
                is_bru  = 1'b1;
                jump    = 1'b1;
                writes  = 1'b1;
                use_pc  = 1'b1;
                use_imm = 1'b1;
                imm_o   = {{(`XLEN-20){insn_i.j.imm20}}, insn_i.j.imm19_12,
                           insn_i.j.imm11, insn_i.j.imm10_1, 1'b0};
            end
            default: ; // unsupported, retires as a no-op
        endcase
    end

    assign src_ctrl_o = '{use_pc: use_pc, use_imm: use_imm};
    assign alu_ctrl_o = '{en: legal && is_alu, op: alu_op};
    assign bru_ctrl_o = '{en: legal && is_bru, jump: jump, cmp: cmp};
    assign wb_ctrl_o  = '{rf_we: legal && writes && (insn_i.r.rd != '0), rd: insn_i.r.rd};
    assign rs1_o      = insn_i.r.rs1; // same position in every format
    assign rs2_o      = insn_i.r.rs2;

    // result is or-ed in execute, so one unit at a time
    always_comb begin
        a_one_unit: assert final (!(alu_ctrl_o.en && bru_ctrl_o.en))
            else $error("alu and branch unit both enabled");
    end

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`include "core_config.svh"
`default_nettype none

module exec_unit (
    input  var core_pkg::alu_ctrl_s alu_ctrl_i,
    input  var core_pkg::bru_ctrl_s bru_ctrl_i,
    input  var logic [`XLEN-1:0]    src1_i,
    input  var logic [`XLEN-1:0]    src2_i,
    input  var logic [`XLEN-1:0]    pc_i,
    input  var logic [`XLEN-1:0]    imm_i,
    output var logic [`XLEN-1:0]    rslt_o,
    output var logic                tkn_o,
    output var logic [`XLEN-1:0]    tkn_pc_o
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic [`XLEN-1:0]         alu_rslt;
    logic [`XLEN-1:0]         bru_rslt;
    logic                     cond;

    assign shamt = src2_i[$clog2(`XLEN)-1:0];

    // alu, zero when idle so results can be or-ed
    always_comb begin
        alu_rslt = '0;
        if (alu_ctrl_i.en) begin
            case (alu_ctrl_i.op)
                core_pkg::ALU_ADD:   alu_rslt = src1_i + src2_i;
                core_pkg::ALU_SUB:   alu_rslt = src1_i - src2_i;
                core_pkg::ALU_AND:   alu_rslt = src1_i & src2_i;
                core_pkg::ALU_OR:    alu_rslt = src1_i | src2_i;
                core_pkg::ALU_XOR:   alu_rslt = src1_i ^ src2_i;
                core_pkg::ALU_SLL:   alu_rslt = src1_i << shamt;
                core_pkg::ALU_SRL:   alu_rslt = src1_i >> shamt;
                core_pkg::ALU_SRA:   alu_rslt = $signed(src1_i) >>> shamt;
                core_pkg::ALU_SLT:
                    alu_rslt = {{(`XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
                core_pkg::ALU_SLTU:
                    alu_rslt = {{(`XLEN-1){1'b0}}, src1_i < src2_i};
                core_pkg::ALU_PASSB: alu_rslt = src2_i;
                default:             alu_rslt = '0;
            endcase
        end
    end

    // branch compare
    always_comb begin
        case (bru_ctrl_i.cmp)
            core_pkg::CMP_EQ: cond = (src1_i == src2_i);
            core_pkg::CMP_NE: cond = (src1_i != src2_i);
            core_pkg::CMP_LT: cond = ($signed(src1_i) < $signed(src2_i));
            default:          cond = ($signed(src1_i) >= $signed(src2_i));
        endcase
    end

    assign tkn_o    = bru_ctrl_i.en && (bru_ctrl_i.jump || cond);
    assign tkn_pc_o = pc_i + imm_i;
    assign bru_rslt = (bru_ctrl_i.en && bru_ctrl_i.jump) ? pc_i + 'd4 : '0; // jal link

    assign rslt_o = alu_rslt | bru_rslt;

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`include "core_config.svh"

package isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0]        imm;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } i_fmt_s;

    typedef struct packed {
        logic               imm12;
        logic [5:0]         imm10_5;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [3:0]         imm4_1;
        logic               imm11;
        opcode_e            opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0]        imm31_12;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } u_fmt_s;

    typedef struct packed {
        logic               imm20;
        logic [9:0]         imm10_1;
        logic               imm11;
        logic [7:0]         imm19_12;
        logic [`REG_AW-1:0] rd;
        opcode_e            opcode;
    } j_fmt_s;

    // one instruction word, seen through each format
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        b_fmt_s b;
        u_fmt_s u;
        j_fmt_s j;
    } insn_u;

endpackage

// ==== rtl/regfile.sv ====
`include "core_config.svh"
`default_nettype none

module regfile (
    input  var logic               clk_i,
    input  var logic [`REG_AW-1:0] rs1_i,
    input  var logic [`REG_AW-1:0] rs2_i,
    output var logic [`XLEN-1:0]   rdata1_o,
    output var logic [`XLEN-1:0]   rdata2_o,
    input  var logic               we_i,
    input  var logic [`REG_AW-1:0] rd_i,
    input  var logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge clk_i) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 is hardwired, its entry is never read
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    a_x0_rd1: assert property (@(posedge clk_i) (rs1_i == '0) |-> (rdata1_o == '0))
        else $error("x0 read nonzero on port 1");
    a_x0_rd2: assert property (@(posedge clk_i) (rs2_i == '0) |-> (rdata2_o == '0))
        else $error("x0 read nonzero on port 2");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_core \
    --Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

// ==== tests/tb_core.sv ====
`include "core_config.svh"
`default_nettype none

module tb_core;

    localparam int PROG_WORDS     = 200;
    localparam int LAST_WORD      = PROG_WORDS - 1;
    localparam int DIRECTED_WORDS = 9;   // hand-written prologue
    localparam int DEP_WORDS      = 7;   // prologue words that chain results
    localparam int CYCLE_LIMIT    = 4 * PROG_WORDS + 50;
    localparam int N_TESTS        = 6;
    localparam int T_RESET        = 0;
    localparam int T_ALU          = 1;
    localparam int T_DEP          = 2;
    localparam int T_BRANCH       = 3;
    localparam int T_X0ILL        = 4;
    localparam int T_DONE         = 5;

    typedef struct packed {
        core_pkg::retire_s rec;
        logic [2:0]        test; // which behavior this record belongs to
    } expect_s;

    logic              clk;
    logic              rst;
    logic [`XLEN-1:0]  imem_addr;
    logic [`ILEN-1:0]  imem_rdata;
    core_pkg::retire_s retire;

    logic [`ILEN-1:0]  prog [PROG_WORDS];
    expect_s           exp_q [$];
    logic [`XLEN-1:0]  fetch_addr;
    int                cycles = 0;
    bit                done   = 1'b0;
    int                chk_cnt [N_TESTS];
    int                err_cnt [N_TESTS];
    string             test_name [N_TESTS] = '{"reset", "alu", "forwarding", "branch",
                                               "x0/illegal", "completion"};

    core_top UUT (
        .clk_i        (clk       ),
        .rst_i        (rst       ),
        .imem_addr_o  (imem_addr ),
        .imem_rdata_i (imem_rdata),
        .retire_o     (retire    )
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [`ILEN-1:0] mem_word(input logic [`XLEN-1:0] addr);
        if (addr < PROG_WORDS * 4) begin
            return prog[int'(addr >> 2)];
        end
        return addr ^ 32'h5A3C_96E1; // only fetched on squashed paths past the program
    endfunction

    // synchronous instruction memory returns the word for last cycle's address
    always @(negedge clk) fetch_addr = imem_addr;
    always @(posedge clk) begin
        #1 imem_rdata = mem_word(fetch_addr);
    end

    function automatic int rnd(input int n);
        return int'($urandom % n);
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'($urandom % 8); // small set so dependencies are frequent
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] random_word(input int i);
        int         kind;
        int         room;
        int         sel;
        logic [2:0] f3;
        kind = rnd(100);
        room = LAST_WORD - i; // forward targets must stay inside the program
        if (room > 8) room = 8;
        if (kind < 30) begin
            sel = rnd(10);
            case (sel)
                1:       return enc_r(7'h20, 3'b000, rnd_reg(), rnd_reg(), rnd_reg());
                7:       return enc_r(7'h20, 3'b101, rnd_reg(), rnd_reg(), rnd_reg());
                8:       return enc_r(7'h00, 3'b110, rnd_reg(), rnd_reg(), rnd_reg());
                9:       return enc_r(7'h00, 3'b111, rnd_reg(), rnd_reg(), rnd_reg());
                default: return enc_r(7'h00, 3'((sel == 0) ? 0 : sel - 1), rnd_reg(),
                                      rnd_reg(), rnd_reg());
            endcase
        end else if (kind < 60) begin
            sel = rnd(9);
            case (sel)
                6:       return enc_i({7'h00, 5'($urandom)}, 3'b001, rnd_reg(), rnd_reg());
                7:       return enc_i({7'h00, 5'($urandom)}, 3'b101, rnd_reg(), rnd_reg());
                8:       return enc_i({7'h20, 5'($urandom)}, 3'b101, rnd_reg(), rnd_reg());
                default: begin
                    f3 = (sel == 0) ? 3'b000 : (sel < 4) ? 3'(sel + 1) : 3'(sel + 2);
                    return enc_i(12'($urandom), f3, rnd_reg(), rnd_reg());
                end
            endcase
        end else if (kind < 68) begin
            return enc_lui(20'($urandom), rnd_reg());
        end else if (kind < 82 && room >= 2) begin
            sel = rnd(4);
            f3  = (sel < 2) ? 3'(sel) : 3'(sel + 2); // beq bne blt bge
            return enc_b(f3, rnd_reg(), rnd_reg(), 13'((2 + rnd(room - 1)) * 4));
        end else if (kind < 88 && room >= 2) begin
            return enc_jal(rnd_reg(), 21'((2 + rnd(room - 1)) * 4));
        end else if (kind < 93) begin
            if (rnd(2) == 0) begin
                return {12'($urandom), rnd_reg(), 3'b010, rnd_reg(), 7'b0000011}; // lw
            end
            return enc_r(7'h01, 3'b000, rnd_reg(), rnd_reg(), rnd_reg()); // mul
        end
        return enc_i(12'($urandom), 3'b000, 5'd0, rnd_reg()); // write to x0
    endfunction

    task automatic build_program();
        prog[0] = enc_lui(20'($urandom), 5'd1);
        prog[1] = enc_i(12'($urandom), 3'b000, 5'd2, 5'd1);  // x1 one back
        prog[2] = enc_r(7'h00, 3'b100, 5'd3, 5'd1, 5'd2);    // x1 two back and x2 one back
        prog[3] = enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd2);
        prog[4] = enc_i(12'($urandom), 3'b000, 5'd5, 5'd4);
        prog[5] = enc_lui(20'($urandom), 5'd6);
        prog[6] = enc_r(7'h00, 3'b110, 5'd7, 5'd6, 5'd5);
        prog[7] = enc_i(12'($urandom), 3'b000, 5'd0, 5'd7);  // x0 must stay zero
        prog[8] = enc_r(7'h00, 3'b000, 5'd5, 5'd0, 5'd7);
        for (int i = DIRECTED_WORDS; i < LAST_WORD; i++) begin
            prog[i] = random_word(i);
        end
        prog[LAST_WORD] = enc_jal(5'd0, 21'd0); // jump to self
    endtask

    // reference arithmetic shared by register and immediate forms
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_expected();
        logic [`XLEN-1:0] x [`NREGS];
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] next;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] imm;
        logic             wr;
        logic             legal;
        logic             taken;
        logic             at_end;
        isa_pkg::insn_u   w;
        expect_s          e;
        for (int r = 0; r < `NREGS; r++) x[r] = '0;
        pc     = `RESET_VECTOR;
        at_end = 1'b0;
        while (!at_end && exp_q.size() < PROG_WORDS) begin
            w     = prog[int'(pc >> 2)];
            next  = pc + 32'd4;
            res   = '0;
            wr    = 1'b0;
            legal = 1'b1;
            taken = 1'b0;
            case (w.r.opcode)
                isa_pkg::OP: begin
                    wr    = 1'b1;
                    legal = (w.r.funct7 == 7'h00) || ((w.r.funct7 == 7'h20) &&
                            ((w.r.funct3 == 3'b000) || (w.r.funct3 == 3'b101)));
                    res   = alu_ref(w.r.funct3, w.r.funct7[5], x[w.r.rs1], x[w.r.rs2]);
                end
                isa_pkg::OP_IMM: begin
                    wr  = 1'b1;
                    imm = {{20{w.i.imm[11]}}, w.i.imm};
                    if (w.i.funct3 == 3'b001) legal = (w.r.funct7 == 7'h00);
                    if (w.i.funct3 == 3'b101) legal = (w.r.funct7 == 7'h00) ||
                                                      (w.r.funct7 == 7'h20);
                    res = alu_ref(w.i.funct3, (w.i.funct3 == 3'b101) && w.r.funct7[5],
                                  x[w.i.rs1], imm);
                end
                isa_pkg::LUI: begin
                    wr  = 1'b1;
                    res = {w.u.imm31_12, 12'h000};
                end
                isa_pkg::BRANCH: begin
                    imm = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5,
                           w.b.imm4_1, 1'b0};
                    case (w.b.funct3)
                        3'b000:  taken = (x[w.b.rs1] == x[w.b.rs2]);
                        3'b001:  taken = (x[w.b.rs1] != x[w.b.rs2]);
                        3'b100:  taken = ($signed(x[w.b.rs1]) < $signed(x[w.b.rs2]));
                        3'b101:  taken = ($signed(x[w.b.rs1]) >= $signed(x[w.b.rs2]));
                        default: legal = 1'b0;
                    endcase
                    if (legal && taken) next = pc + imm;
                end
                isa_pkg::JAL: begin
                    wr   = 1'b1;
                    imm  = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
                            w.j.imm10_1, 1'b0};
                    res  = pc + 32'd4;
                    next = pc + imm;
                end
                default: legal = 1'b0;
            endcase
            e.rec = '{valid: 1'b1, pc: pc, we: legal && wr && (w.r.rd != 5'd0),
                      rd: w.r.rd, data: res};
            if (e.rec.we) x[w.r.rd] = res;
            if (!legal || (wr && w.r.rd == 5'd0)) e.test = 3'(T_X0ILL);
            else if (w.r.opcode == isa_pkg::BRANCH || w.r.opcode == isa_pkg::JAL)
                e.test = 3'(T_BRANCH);
            else if (int'(pc >> 2) < DEP_WORDS) e.test = 3'(T_DEP);
            else e.test = 3'(T_ALU);
            exp_q.push_back(e);
            at_end = (int'(pc >> 2) == LAST_WORD);
            pc     = next;
        end
    endtask

    task automatic compare_value(input int test, input string name,
                                 input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        chk_cnt[test]++;
        value_match: assert (got == exp)
            else begin
                $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
                err_cnt[test]++;
            end
    endtask

    // compares each committed instruction with the model in program order
    always @(negedge clk) begin
        expect_s e;
        if (!rst && retire.valid && !done) begin
            e = exp_q.pop_front();
            compare_value(int'(e.test), "retire_o.pc", retire.pc, e.rec.pc);
            compare_value(int'(e.test), "retire_o.we", 32'(retire.we), 32'(e.rec.we));
            if (e.rec.we) begin
                compare_value(int'(e.test), "retire_o.rd", 32'(retire.rd), 32'(e.rec.rd));
                compare_value(int'(e.test), "retire_o.data", retire.data, e.rec.data);
            end
            if (exp_q.size() == 0) done = 1'b1; // self-jump matched
        end
    end

    task automatic report_test(input int test);
        $display("test %s: %0d checks, %0d errors", test_name[test], chk_cnt[test],
                 err_cnt[test]);
    endtask

    initial begin
        int total_chk;
        int total_err;
        clk        = 1'b0;
        rst        = 1'b1;
        imem_rdata = '0;
        fetch_addr = `RESET_VECTOR;
        for (int t = 0; t < N_TESTS; t++) begin
            chk_cnt[t] = 0;
            err_cnt[t] = 0;
        end
        void'($urandom(11988));
        build_program();
        build_expected();

        @(posedge clk);
        @(negedge clk);
        compare_value(T_RESET, "retire_o.valid", 32'(retire.valid), 32'd0);
        @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            compare_value(T_RESET, "retire_o.valid", 32'(retire.valid), 32'd0);
        end
        @(negedge clk); // first commit in the third cycle after release
        compare_value(T_RESET, "retire_o.valid", 32'(retire.valid), 32'd1);
        compare_value(T_RESET, "retire_o.pc", retire.pc, `RESET_VECTOR);
        report_test(T_RESET);

        while (!done && cycles < CYCLE_LIMIT) @(negedge clk);
        chk_cnt[T_DONE]++;
        reached_end: assert (done)
            else begin
                $display("timeout after %0d cycles with %0d retire records still expected",
                         cycles, exp_q.size());
                err_cnt[T_DONE]++;
            end
        for (int t = T_ALU; t < N_TESTS; t++) report_test(t);

        total_chk = 0;
        total_err = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_chk += chk_cnt[t];
            total_err += err_cnt[t];
        end
        $display("%0d checks in %0d tests, %0d errors", total_chk, N_TESTS, total_err);
        if (total_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/exec_unit.sv
rtl/core_top.sv
tests/tb_core.sv
